/* rtl/mem_pkg.sv */
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // bus and memory sizes
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // byte addresses 0x000 to 0xfff map onto the array
  localparam int mem_words = 1024;
  localparam int idx_w = $clog2(mem_words);

  // ~~~~~~~~~~~~~~~~~~~~
  // wait-cycle generator
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int lfsr_w = 8;
  localparam logic [lfsr_w-1:0] lfsr_seed = 8'hA5;

  // x^8 + x^6 + x^5 + x^4 + 1 for a right-shifting Galois register
  localparam logic [lfsr_w-1:0] lfsr_taps = 8'hB8;

  // three bits give a wait count of 0 to 7 cycles
  localparam int delay_w = 3;

  // ~~~~~~~~~~~~~~~~~~~~
  // channel types
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_WAIT,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RESP_OKAY = 1'b0,
    RESP_ERR  = 1'b1
  } resp_e;

endpackage

/* rtl/delay_lfsr.sv */
`timescale 1ns/1ps

module delay_lfsr (
  input  logic                       clk,
  input  logic                       rst,
  output logic [mem_pkg::lfsr_w-1:0] lfsr
);

  logic [mem_pkg::lfsr_w-1:0] shifted;
  logic [mem_pkg::lfsr_w-1:0] lfsr_next;

  // shift right and fold the bit that drops out back in through the taps
  always_comb begin
    shifted = lfsr >> 1;
    if (lfsr[0]) begin
      lfsr_next = shifted ^ mem_pkg::lfsr_taps;
    end else begin
      lfsr_next = shifted;
    end
  end

  // the seed is nonzero so the register never locks up in the all-zero state
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= mem_pkg::lfsr_seed;
    end else begin
      lfsr <= lfsr_next;
    end
  end

endmodule

/* rtl/sram_array.sv */
`timescale 1ns/1ps

module sram_array (
  input  logic                       clk,

  input  logic                       ren,
  input  logic [mem_pkg::idx_w-1:0]  ridx,
  output logic [mem_pkg::data_w-1:0] rdata_q,

  input  logic                       wen,
  input  logic [mem_pkg::idx_w-1:0]  widx,
  input  logic [mem_pkg::data_w-1:0] wdata,
  input  logic [mem_pkg::strb_w-1:0] wbe
);

  logic [mem_pkg::data_w-1:0] mem [mem_pkg::mem_words];

  // each enable bit guards one byte lane of the addressed word
  always_ff @(posedge clk) begin
    if (wen) begin
      for (int b = 0; b < mem_pkg::strb_w; b++) begin
        if (wbe[b]) begin
          mem[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // read word stays put until the next read strobe
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata_q <= mem[ridx];
    end
  end

endmodule

/* rtl/axil_slave_ctrl.sv */
`timescale 1ns/1ps

module axil_slave_ctrl (
  input  logic                       clk,
  input  logic                       rst,

  input  logic [mem_pkg::addr_w-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,

  output logic [mem_pkg::data_w-1:0] rdata,
  output mem_pkg::resp_e             rresp,
  output logic                       rvalid,
  input  logic                       rready,

  input  logic [mem_pkg::addr_w-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,

  input  logic [mem_pkg::data_w-1:0] wdata,
  input  logic [mem_pkg::strb_w-1:0] wstrb,
  input  logic                       wvalid,
  output logic                       wready,

  output mem_pkg::resp_e             bresp,
  output logic                       bvalid,
  input  logic                       bready,

  input  logic [mem_pkg::lfsr_w-1:0] lfsr,

  output logic                       ren,
  output logic [mem_pkg::idx_w-1:0]  ridx,
  input  logic [mem_pkg::data_w-1:0] rdata_q,
  output logic                       wen,
  output logic [mem_pkg::idx_w-1:0]  widx,
  output logic [mem_pkg::data_w-1:0] wdata_mem,
  output logic [mem_pkg::strb_w-1:0] wbe
);

  mem_pkg::rd_state_e rd_state;
  logic [mem_pkg::delay_w-1:0] rd_cnt;
  logic [mem_pkg::idx_w-1:0]   rd_idx_q;
  logic                        rd_err_q;

  mem_pkg::wr_state_e wr_state;
  logic [mem_pkg::delay_w-1:0] wr_cnt;
  logic [mem_pkg::idx_w-1:0]   wr_idx_q;
  logic                        wr_err_q;
  logic [mem_pkg::data_w-1:0]  wdata_q;
  logic [mem_pkg::strb_w-1:0]  wstrb_q;

  // the depth is a power of two, so any set bit above the word index is out of range
  function automatic logic out_of_range(input logic [mem_pkg::addr_w-1:0] addr);
    return addr[mem_pkg::addr_w-1:mem_pkg::idx_w+2] != '0;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // read channel
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= mem_pkg::RD_IDLE;
      arready  <= 1'b1;
      rvalid   <= 1'b0;
      rresp    <= mem_pkg::RESP_OKAY;
    end else begin
      case (rd_state)
        mem_pkg::RD_IDLE: begin
          if (arvalid) begin
            arready  <= 1'b0;
            rd_state <= mem_pkg::RD_WAIT;
          end
        end
        mem_pkg::RD_WAIT: begin
          if (rd_cnt == '0) begin
            rvalid   <= 1'b1;
            rresp    <= rd_err_q ? mem_pkg::RESP_ERR : mem_pkg::RESP_OKAY;
            rd_state <= mem_pkg::RD_RESP;
          end
        end
        mem_pkg::RD_RESP: begin
          if (rready) begin
            rvalid   <= 1'b0;
            arready  <= 1'b1;
            rd_state <= mem_pkg::RD_IDLE;
          end
        end
        default: rd_state <= mem_pkg::RD_IDLE;
      endcase
    end
  end

  // address, range flag and wait count are captured on the address handshake
  always_ff @(posedge clk) begin
    if (rd_state == mem_pkg::RD_IDLE && arvalid) begin
      rd_idx_q <= araddr[mem_pkg::idx_w+1:2];
      rd_err_q <= out_of_range(araddr);
      rd_cnt   <= lfsr[mem_pkg::delay_w-1:0];
    end else if (rd_state == mem_pkg::RD_WAIT && rd_cnt != '0) begin
      rd_cnt <= rd_cnt - 1'b1;
    end
  end

  assign ren   = (rd_state == mem_pkg::RD_WAIT) && (rd_cnt == '0) && !rd_err_q;
  assign ridx  = rd_idx_q;
  assign rdata = (rresp == mem_pkg::RESP_ERR) ? '0 : rdata_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // write channel
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= mem_pkg::WR_IDLE;
      awready  <= 1'b1;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= mem_pkg::RESP_OKAY;
    end else begin
      case (wr_state)
        mem_pkg::WR_IDLE: begin
          if (awvalid) begin
            awready  <= 1'b0;
            wready   <= 1'b1;
            wr_state <= mem_pkg::WR_DATA;
          end
        end
        mem_pkg::WR_DATA: begin
          if (wvalid) begin
            wready   <= 1'b0;
            wr_state <= mem_pkg::WR_WAIT;
          end
        end
        mem_pkg::WR_WAIT: begin
          if (wr_cnt == '0) begin
            bvalid   <= 1'b1;
            bresp    <= wr_err_q ? mem_pkg::RESP_ERR : mem_pkg::RESP_OKAY;
            wr_state <= mem_pkg::WR_RESP;
          end
        end
        mem_pkg::WR_RESP: begin
          if (bready) begin
            bvalid   <= 1'b0;
            awready  <= 1'b1;
            wr_state <= mem_pkg::WR_IDLE;
          end
        end
        default: wr_state <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state == mem_pkg::WR_IDLE && awvalid) begin
      wr_idx_q <= awaddr[mem_pkg::idx_w+1:2];
      wr_err_q <= out_of_range(awaddr);
    end
  end

  // upper nibble of the LFSR so the write wait differs from the read wait
  always_ff @(posedge clk) begin
    if (wr_state == mem_pkg::WR_DATA && wvalid) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
      wr_cnt  <= lfsr[4 +: mem_pkg::delay_w];
    end else if (wr_state == mem_pkg::WR_WAIT && wr_cnt != '0) begin
      wr_cnt <= wr_cnt - 1'b1;
    end
  end

  assign wen       = (wr_state == mem_pkg::WR_WAIT) && (wr_cnt == '0) && !wr_err_q;
  assign widx      = wr_idx_q;
  assign wdata_mem = wdata_q;
  assign wbe       = wstrb_q;

endmodule

/* rtl/mem_sys_top.sv */
`timescale 1ns/1ps

module mem_sys_top (
  input  logic                       clk,
  input  logic                       rst,

  input  logic [mem_pkg::addr_w-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,

  output logic [mem_pkg::data_w-1:0] rdata,
  output mem_pkg::resp_e             rresp,
  output logic                       rvalid,
  input  logic                       rready,

  input  logic [mem_pkg::addr_w-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,

  input  logic [mem_pkg::data_w-1:0] wdata,
  input  logic [mem_pkg::strb_w-1:0] wstrb,
  input  logic                       wvalid,
  output logic                       wready,

  output mem_pkg::resp_e             bresp,
  output logic                       bvalid,
  input  logic                       bready
);

  logic [mem_pkg::lfsr_w-1:0] lfsr;

  logic                       ren;
  logic [mem_pkg::idx_w-1:0]  ridx;
  logic [mem_pkg::data_w-1:0] rdata_q;
  logic                       wen;
  logic [mem_pkg::idx_w-1:0]  widx;
  logic [mem_pkg::data_w-1:0] wdata_mem;
  logic [mem_pkg::strb_w-1:0] wbe;

  axil_slave_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .lfsr      (lfsr),
    .ren       (ren),
    .ridx      (ridx),
    .rdata_q   (rdata_q),
    .wen       (wen),
    .widx      (widx),
    .wdata_mem (wdata_mem),
    .wbe       (wbe)
  );

  sram_array i_sram (
    .clk     (clk),
    .ren     (ren),
    .ridx    (ridx),
    .rdata_q (rdata_q),
    .wen     (wen),
    .widx    (widx),
    .wdata   (wdata_mem),
    .wbe     (wbe)
  );

  delay_lfsr i_lfsr (
    .clk  (clk),
    .rst  (rst),
    .lfsr (lfsr)
  );

endmodule

/* bench/tb_mem_sys.sv */
`timescale 1ns/1ps

module tb_mem_sys;

  localparam int timeout_cycles = 100;

  logic                       clk;
  logic                       rst;
  logic [mem_pkg::addr_w-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [mem_pkg::data_w-1:0] rdata;
  mem_pkg::resp_e             rresp;
  logic                       rvalid;
  logic                       rready;
  logic [mem_pkg::addr_w-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [mem_pkg::data_w-1:0] wdata;
  logic [mem_pkg::strb_w-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  mem_pkg::resp_e             bresp;
  logic                       bvalid;
  logic                       bready;

  int          mismatches;
  int          failures;
  logic [31:0] lcg_state;

  mem_sys_top i_dut (.*);

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~

  // a ready stays low for 0 to 5 cycles after valid shows up
  function automatic int next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[23:16] % 8'd6);
  endfunction

  task automatic check_word(input string name, input logic [mem_pkg::data_w-1:0] got,
                            input logic [mem_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_resp(input string name, input mem_pkg::resp_e got,
                            input mem_pkg::resp_e exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s", what);
    failures++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // channel drivers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic do_read(input logic [mem_pkg::addr_w-1:0] addr,
                         input mem_pkg::resp_e exp_resp,
                         input logic [mem_pkg::data_w-1:0] exp_data);
    int                         n;
    int                         hold;
    logic [mem_pkg::data_w-1:0] first_data;
    mem_pkg::resp_e             first_resp;
    araddr  <= addr;
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < timeout_cycles);
    arvalid <= 1'b0;
    if (!arready) begin
      report_timeout("arready");
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
      check_bit("arready", arready, 1'b0);
    end while (!rvalid && n < timeout_cycles);
    if (!rvalid) begin
      report_timeout("rvalid");
      return;
    end
    // the response must sit still while the bench stalls
    first_data = rdata;
    first_resp = rresp;
    hold = next_delay();
    repeat (hold) begin
      @(posedge clk);
      check_bit("rvalid", rvalid, 1'b1);
      check_bit("arready", arready, 1'b0);
      check_word("rdata", rdata, first_data);
      check_resp("rresp", rresp, first_resp);
    end
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    check_bit("rvalid", rvalid, 1'b1);
    check_bit("arready", arready, 1'b0);
    check_word("rdata", rdata, exp_data);
    check_resp("rresp", rresp, exp_resp);
    @(posedge clk);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("arready", arready, 1'b1);
  endtask

  task automatic do_write(input logic [mem_pkg::addr_w-1:0] addr,
                          input logic [mem_pkg::data_w-1:0] data,
                          input logic [mem_pkg::strb_w-1:0] strb,
                          input mem_pkg::resp_e exp_resp);
    int             n;
    int             hold;
    mem_pkg::resp_e first_resp;
    awaddr  <= addr;
    awvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!awready && n < timeout_cycles);
    awvalid <= 1'b0;
    if (!awready) begin
      report_timeout("awready");
      return;
    end
    wdata  <= data;
    wstrb  <= strb;
    wvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!wready && n < timeout_cycles);
    wvalid <= 1'b0;
    if (!wready) begin
      report_timeout("wready");
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
      check_bit("awready", awready, 1'b0);
      check_bit("wready", wready, 1'b0);
    end while (!bvalid && n < timeout_cycles);
    if (!bvalid) begin
      report_timeout("bvalid");
      return;
    end
    first_resp = bresp;
    hold = next_delay();
    repeat (hold) begin
      @(posedge clk);
      check_bit("bvalid", bvalid, 1'b1);
      check_bit("awready", awready, 1'b0);
      check_resp("bresp", bresp, first_resp);
    end
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    check_bit("bvalid", bvalid, 1'b1);
    check_bit("awready", awready, 1'b0);
    check_resp("bresp", bresp, exp_resp);
    @(posedge clk);
    check_bit("bvalid", bvalid, 1'b0);
    check_bit("awready", awready, 1'b1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op;
    logic [31:0] aw;
    logic [31:0] wd;
    logic [31:0] ws;
    logic [31:0] ar;
    logic [31:0] br;
    logic [31:0] rr;
    logic [31:0] rd;
    clk        = 1'b0;
    rst        = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    mismatches = 0;
    failures   = 0;
    lcg_state  = 32'h0748_0691;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("arready", arready, 1'b1);
    check_bit("awready", awready, 1'b1);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("bvalid", bvalid, 1'b0);
    check_bit("wready", wready, 1'b0);

    fd = $fopen("bench/mem_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/mem_tests.txt");
      failures++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          // comment and blank lines do not parse as eight fields
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h", op, aw, wd, ws, ar, br, rr, rd);
          if (fields == 8) begin
            case (op)
              32'd0: do_write(aw, wd, ws[3:0], mem_pkg::resp_e'(br[0]));
              32'd1: do_read(ar, mem_pkg::resp_e'(rr[0]), rd);
              32'd2: begin
                fork
                  do_write(aw, wd, ws[3:0], mem_pkg::resp_e'(br[0]));
                  do_read(ar, mem_pkg::resp_e'(rr[0]), rd);
                join
              end
              default: begin
                $display("unknown op code %h in the test file", op);
                failures++;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* bench/mem_tests.txt */
# op awaddr wdata wstrb araddr bresp rresp rdata, all hex
# op 0 write, 1 read, 2 write and read together; unused fields hold 0
0 00000000 deadbeef f 00000000 0 0 00000000
1 00000000 00000000 0 00000000 0 0 deadbeef
0 00000004 cafef00d f 00000000 0 0 00000000
1 00000000 00000000 0 00000004 0 0 cafef00d
0 00000ffc 0badc0de f 00000000 0 0 00000000
1 00000000 00000000 0 00000ffc 0 0 0badc0de
# byte lanes merged over 11223344 at 0x10
0 00000010 11223344 f 00000000 0 0 00000000
0 00000010 aabbccdd 1 00000000 0 0 00000000
1 00000000 00000000 0 00000010 0 0 112233dd
0 00000010 55667788 6 00000000 0 0 00000000
1 00000000 00000000 0 00000010 0 0 116677dd
0 00000010 99000000 8 00000000 0 0 00000000
1 00000000 00000000 0 00000010 0 0 996677dd
# out of range, some of these alias to word 0 if the range check fails
0 00001000 ffffffff f 00000000 1 0 00000000
1 00000000 00000000 0 00001000 0 1 00000000
0 80000000 12345678 f 00000000 1 0 00000000
1 00000000 00000000 0 0000fff0 0 1 00000000
1 00000000 00000000 0 00000000 0 0 deadbeef
1 00000000 00000000 0 00000004 0 0 cafef00d
1 00000000 00000000 0 00000ffc 0 0 0badc0de
1 00000000 00000000 0 00000010 0 0 996677dd
# write and read in flight together
2 00000020 13572468 f 00000004 0 0 cafef00d
2 00000024 a5a5a5a5 f 00000020 0 0 13572468
2 00002000 ffffffff f 00000024 1 0 a5a5a5a5
2 00000028 5a5a0f0f f 00001004 0 1 00000000
1 00000000 00000000 0 00000028 0 0 5a5a0f0f
1 00000000 00000000 0 00000000 0 0 deadbeef

/* sim.f */
rtl/mem_pkg.sv
rtl/delay_lfsr.sv
rtl/sram_array.sv
rtl/axil_slave_ctrl.sv
rtl/mem_sys_top.sv
bench/tb_mem_sys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
DUT_TOP   ?= mem_sys_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Verification passed

RTL_SRCS := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
